//--- files.f
verilog/host_bus_pkg.sv
verilog/qdr_bus_pkg.sv
verilog/host_req_port.sv
verilog/qdr_cmd_issue.sv
verilog/qdr_read_collect.sv
verilog/qdr_host_bridge.sv
test/qdr_sram_model.sv
test/tb_qdr_host_bridge.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_qdr_host_bridge
FILELIST = files.f

PASS_MSG = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- test/tb_qdr_host_bridge.sv
`timescale 1ns/10ps

module tb_qdr_host_bridge;

  localparam int QDR_LATENCY    = 10;
  localparam int N_RANDOM       = 200;
  localparam int N_DIRECTED     = 32;
  localparam int TIMEOUT_CYCLES = (N_RANDOM + N_DIRECTED) * 60;

  logic        host_clk;
  logic        host_rst;
  logic        host_en;
  logic        host_rnw;
  logic [31:0] host_addr;
  logic [31:0] host_wdata;
  logic [3:0]  host_be;
  logic [31:0] host_rdata;
  logic        host_ack;
  logic        qdr_clk;
  logic        qdr_rst;
  logic        qdr_req;
  logic        qdr_ack;
  logic [35:0] qdr_q;
  logic [1:0]  ack_delay;
  qdr_bus_pkg::qdr_cmd_t qdr_cmd;

  logic [31:0] ref_mem [0:63];
  logic [15:0] lfsr_state;
  logic        first_en_seen;
  logic        beat1_check;
  logic        exp_rnw;
  logic [31:0] exp_addr;
  logic [31:0] exp_wdata;
  logic [3:0]  exp_be;
  int          req_cycles;
  int          en_count;
  int          ack_count;
  int          cycle_cnt;

  qdr_host_bridge #(
    .QDR_LATENCY (QDR_LATENCY)
  ) uut (
    .host_clk   (host_clk),
    .host_rst   (host_rst),
    .host_en    (host_en),
    .host_rnw   (host_rnw),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_be    (host_be),
    .host_rdata (host_rdata),
    .host_ack   (host_ack),
    .qdr_clk    (qdr_clk),
    .qdr_rst    (qdr_rst),
    .qdr_req    (qdr_req),
    .qdr_ack    (qdr_ack),
    .qdr_cmd    (qdr_cmd),
    .qdr_q      (qdr_q)
  );

  qdr_sram_model #(
    .QDR_LATENCY (QDR_LATENCY)
  ) u_sram (
    .qdr_clk   (qdr_clk),
    .qdr_rst   (qdr_rst),
    .ack_delay (ack_delay),
    .qdr_req   (qdr_req),
    .qdr_cmd   (qdr_cmd),
    .qdr_ack   (qdr_ack),
    .qdr_q     (qdr_q)
  );

  initial begin
    qdr_clk = 1'b0;
    forever #20 qdr_clk = ~qdr_clk;
  end

  initial begin
    host_clk = 1'b0;
    forever #28 host_clk = ~host_clk;
  end

  // same fill as the SRAM model after reset
  function automatic logic [31:0] fill_word(input int idx);
    return 32'(idx) * 32'h0104_0811 ^ 32'h5ac3_96e1;
  endfunction

  function automatic logic [31:0] lanes_to_word(input logic [35:0] lanes);
    return {lanes[34:27], lanes[25:18], lanes[16:9], lanes[7:0]};
  endfunction

  function automatic logic lane_tops_zero(input logic [35:0] lanes);
    return !(lanes[35] || lanes[26] || lanes[17] || lanes[8]);
  endfunction

  // 16-bit Fibonacci LFSR with taps 16 14 13 11 and one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  task automatic report_failure;
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  always @(posedge qdr_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout: transfers did not finish within %0d qdr_clk cycles",
               TIMEOUT_CYCLES);
      report_failure();
    end
  end

  always @(posedge host_clk) begin
    if (host_ack) begin
      ack_count = ack_count + 1;
    end
  end

  // command bus monitor sampled mid-cycle
  always @(negedge qdr_clk) begin
    if (!first_en_seen && !qdr_rst) begin
      assert (!qdr_req && !host_ack)
        else begin
          $display("qdr_req or host_ack went high before the first host_en");
          report_failure();
        end
    end
    if (beat1_check) begin
      beat1_check = 1'b0;
      assert (qdr_cmd.be == (exp_addr[2] ? exp_be : 4'h0))
        else begin
          $display("[FAIL] %0t qdr_cmd.be beat1 exp %h got %h", $time,
                   exp_addr[2] ? exp_be : 4'h0, qdr_cmd.be);
          report_failure();
        end
    end
    if (qdr_req) begin
      req_cycles = req_cycles + 1;
      assert (qdr_cmd.addr == exp_addr[31:3])
        else begin
          $display("[FAIL] %0t qdr_cmd.addr exp %h got %h", $time,
                   exp_addr[31:3], qdr_cmd.addr);
          report_failure();
        end
      assert (qdr_cmd.r == exp_rnw && qdr_cmd.w == !exp_rnw)
        else begin
          $display("[FAIL] %0t qdr_cmd.r/w exp %b%b got %b%b", $time,
                   exp_rnw, !exp_rnw, qdr_cmd.r, qdr_cmd.w);
          report_failure();
        end
      if (!exp_rnw) begin
        assert (lane_tops_zero(qdr_cmd.d) && lanes_to_word(qdr_cmd.d) == exp_wdata)
          else begin
            $display("[FAIL] %0t qdr_cmd.d exp %h got %h", $time, exp_wdata, qdr_cmd.d);
            report_failure();
          end
        assert (qdr_cmd.be == (exp_addr[2] ? 4'h0 : exp_be))
          else begin
            $display("[FAIL] %0t qdr_cmd.be beat0 exp %h got %h", $time,
                     exp_addr[2] ? 4'h0 : exp_be, qdr_cmd.be);
            report_failure();
          end
        if (qdr_ack) begin
          beat1_check = 1'b1;
        end
      end
    end
  end

  task automatic run_transfer(input logic rnw, input logic [5:0] widx,
                              input logic [31:0] wdata, input logic [3:0] be,
                              input logic [1:0] delay);
    logic [31:0] addr;
    addr = {24'h0, widx, 2'b00};
    @(posedge host_clk);
    #2;
    exp_rnw       = rnw;
    exp_addr      = addr;
    exp_wdata     = wdata;
    exp_be        = be;
    req_cycles    = 0;
    ack_delay     = delay;
    first_en_seen = 1'b1;
    host_en       = 1'b1;
    host_rnw      = rnw;
    host_addr     = addr;
    host_wdata    = wdata;
    host_be       = be;
    en_count      = en_count + 1;
    @(posedge host_clk);
    #2;
    host_en = 1'b0;
    do begin
      @(negedge host_clk);
    end while (!host_ack);
    if (rnw) begin
      assert (host_rdata == ref_mem[widx])
        else begin
          $display("[FAIL] %0t host_rdata exp %h got %h", $time, ref_mem[widx], host_rdata);
          report_failure();
        end
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          ref_mem[widx][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end
    @(posedge host_clk);
    #1;
    assert (ack_count == en_count)
      else begin
        $display("host_ack count %0d does not match host_en count %0d", ack_count, en_count);
        report_failure();
      end
    assert (req_cycles == int'(delay) + 1)
      else begin
        $display("[FAIL] %0t qdr_req cycles exp %0d got %0d", $time,
                 int'(delay) + 1, req_cycles);
        report_failure();
      end
  endtask

  initial begin
    logic [31:0] r;
    logic [5:0]  widx;
    logic [31:0] wdata;
    logic [3:0]  be;
    host_en       = 1'b0;
    host_rnw      = 1'b0;
    host_addr     = '0;
    host_wdata    = '0;
    host_be       = '0;
    ack_delay     = 2'd0;
    host_rst      = 1'b1;
    qdr_rst       = 1'b1;
    lfsr_state    = 16'd35543;
    first_en_seen = 1'b0;
    beat1_check   = 1'b0;
    exp_rnw       = 1'b0;
    exp_addr      = '0;
    exp_wdata     = '0;
    exp_be        = '0;
    req_cycles    = 0;
    en_count      = 0;
    ack_count     = 0;
    cycle_cnt     = 0;
    for (int i = 0; i < 64; i++) begin
      ref_mem[i] = fill_word(i);
    end
    fork
      begin
        repeat (2) @(posedge qdr_clk);
        #2 qdr_rst = 1'b0;
      end
      begin
        repeat (2) @(posedge host_clk);
        #2 host_rst = 1'b0;
      end
    join

    // idle bus after reset
    repeat (20) @(posedge qdr_clk);

    // write then read back, alternating the beat select bit
    for (int i = 0; i < 8; i++) begin
      r     = take_bits(5);
      widx  = {r[4:0], i[0]};
      wdata = take_bits(32);
      run_transfer(1'b0, widx, wdata, 4'hf, 2'd0);
      r = take_bits(2);
      run_transfer(1'b1, widx, 32'h0, 4'h0, r[1:0]);
    end

    // partial byte enables
    for (int i = 0; i < 4; i++) begin
      r     = take_bits(6);
      widx  = r[5:0];
      wdata = take_bits(32);
      be    = 4'(1 << i) | 4'(i == 3 ? 4'h4 : 4'h0);
      run_transfer(1'b0, widx, wdata, be, 2'd1);
      run_transfer(1'b1, widx, 32'h0, 4'h0, 2'd1);
    end

    // late acknowledge
    for (int i = 0; i < 4; i++) begin
      r     = take_bits(6);
      widx  = r[5:0];
      wdata = take_bits(32);
      r     = take_bits(4);
      run_transfer(1'b0, widx, wdata, r[3:0], 2'd3);
      run_transfer(1'b1, widx, 32'h0, 4'h0, 2'd3);
    end

    // mixed random traffic
    for (int i = 0; i < N_RANDOM; i++) begin
      r     = take_bits(1);
      widx  = 6'(take_bits(6));
      wdata = take_bits(32);
      be    = 4'(take_bits(4));
      run_transfer(r[0], widx, wdata, be, 2'(take_bits(2)));
    end

    repeat (10) @(posedge qdr_clk);
    if (ack_count == en_count) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("unbalanced handshake at end of run");
      report_failure();
    end
    $finish;
  end

endmodule

//--- test/qdr_sram_model.sv
`timescale 1ns/10ps

module qdr_sram_model #(
  parameter int QDR_LATENCY = 10
) (
  input  logic                               qdr_clk,
  input  logic                               qdr_rst,
  input  logic [1:0]                         ack_delay,
  input  logic                               qdr_req,
  input  qdr_bus_pkg::qdr_cmd_t              qdr_cmd,
  output logic                               qdr_ack,
  output logic [qdr_bus_pkg::QDR_DATA_W-1:0] qdr_q
);

  // 32 burst addresses of two beats indexed by {addr, beat}
  logic [35:0] mem [0:63];

  logic [1:0]             wait_cnt;
  logic                   wr_pend;
  logic [4:0]             wr_addr;
  logic [QDR_LATENCY:0]   rd_pipe;
  logic [4:0]             rd_addr [0:QDR_LATENCY];

  function automatic logic [31:0] fill_word(input int idx);
    return 32'(idx) * 32'h0104_0811 ^ 32'h5ac3_96e1;
  endfunction

  function automatic logic [35:0] word_to_lanes(input logic [31:0] word);
    logic [35:0] lanes;
    lanes = '0;
    for (int b = 0; b < 4; b++) begin
      lanes[b*9 +: 8] = word[b*8 +: 8];
    end
    return lanes;
  endfunction

  // ack comes after ack_delay cycles of a pending request
  assign qdr_ack = qdr_req && (wait_cnt == ack_delay);

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      wait_cnt <= 2'd0;
      wr_pend  <= 1'b0;
      wr_addr  <= 5'd0;
      rd_pipe  <= '0;
      for (int i = 0; i <= QDR_LATENCY; i++) begin
        rd_addr[i] <= 5'd0;
      end
      for (int i = 0; i < 64; i++) begin
        mem[i] <= word_to_lanes(fill_word(i));
      end
    end else begin
      if (qdr_req && !qdr_ack) begin
        wait_cnt <= wait_cnt + 2'd1;
      end else begin
        wait_cnt <= 2'd0;
      end

      // write beat 0 in the ack cycle, beat 1 in the next one
      wr_pend <= qdr_ack && qdr_cmd.w;
      if (qdr_ack && qdr_cmd.w) begin
        wr_addr <= qdr_cmd.addr[4:0];
        for (int b = 0; b < 4; b++) begin
          if (qdr_cmd.be[b]) begin
            mem[{qdr_cmd.addr[4:0], 1'b0}][b*9 +: 9] <= qdr_cmd.d[b*9 +: 9];
          end
        end
      end
      if (wr_pend) begin
        for (int b = 0; b < 4; b++) begin
          if (qdr_cmd.be[b]) begin
            mem[{wr_addr, 1'b1}][b*9 +: 9] <= qdr_cmd.d[b*9 +: 9];
          end
        end
      end

      rd_pipe    <= {rd_pipe[QDR_LATENCY-1:0], qdr_ack && qdr_cmd.r};
      rd_addr[0] <= qdr_cmd.addr[4:0];
      for (int i = 1; i <= QDR_LATENCY; i++) begin
        rd_addr[i] <= rd_addr[i-1];
      end
    end
  end

  // beat 0 lands QDR_LATENCY cycles after the ack cycle
  always_comb begin
    if (rd_pipe[QDR_LATENCY-1]) begin
      qdr_q = mem[{rd_addr[QDR_LATENCY-1], 1'b0}];
    end else if (rd_pipe[QDR_LATENCY]) begin
      qdr_q = mem[{rd_addr[QDR_LATENCY], 1'b1}];
    end else begin
      qdr_q = '0;
    end
  end

endmodule

//--- verilog/qdr_host_bridge.sv
`timescale 1ns/10ps

module qdr_host_bridge #(
  parameter int QDR_LATENCY = 10
) (
  input  logic                                 host_clk,
  input  logic                                 host_rst,
  input  logic                                 host_en,
  input  logic                                 host_rnw,
  input  logic [host_bus_pkg::HOST_ADDR_W-1:0] host_addr,
  input  logic [host_bus_pkg::HOST_DATA_W-1:0] host_wdata,
  input  logic [host_bus_pkg::HOST_BE_W-1:0]   host_be,
  output logic [host_bus_pkg::HOST_DATA_W-1:0] host_rdata,
  output logic                                 host_ack,
  input  logic                                 qdr_clk,
  input  logic                                 qdr_rst,
  output logic                                 qdr_req,
  input  logic                                 qdr_ack,
  output qdr_bus_pkg::qdr_cmd_t                qdr_cmd,
  input  logic [qdr_bus_pkg::QDR_DATA_W-1:0]   qdr_q
);

  host_bus_pkg::host_req_t host_req;
  host_bus_pkg::host_req_t cur_req;

  logic                                 trans_lvl;
  logic                                 resp_lvl;
  logic                                 start_strb;
  logic                                 done_strb;
  logic                                 busy_wait;
  logic                                 beat1;
  logic [host_bus_pkg::HOST_DATA_W-1:0] rd_data;

  assign host_req = '{rnw: host_rnw, addr: host_addr, wdata: host_wdata, be: host_be};

  host_req_port u_host_req_port (
    .host_clk     (host_clk),
    .host_rst     (host_rst),
    .host_en      (host_en),
    .host_rdata_q (rd_data),
    .resp_lvl     (resp_lvl),
    .trans_lvl    (trans_lvl),
    .host_rdata   (host_rdata),
    .host_ack     (host_ack)
  );

  qdr_cmd_issue u_qdr_cmd_issue (
    .qdr_clk    (qdr_clk),
    .qdr_rst    (qdr_rst),
    .trans_lvl  (trans_lvl),
    .host_req   (host_req),
    .done_strb  (done_strb),
    .start_strb (start_strb),
    .cur_req    (cur_req),
    .qdr_cmd    (qdr_cmd),
    .qdr_req    (qdr_req),
    .resp_lvl   (resp_lvl),
    .busy_wait  (busy_wait),
    .beat1      (beat1)
  );

  qdr_read_collect #(
    .QDR_LATENCY (QDR_LATENCY)
  ) u_qdr_read_collect (
    .qdr_clk    (qdr_clk),
    .qdr_rst    (qdr_rst),
    .start_strb (start_strb),
    .rnw        (cur_req.rnw),
    .beat_sel   (cur_req.addr[2]),
    .qdr_ack    (qdr_ack),
    .qdr_q      (qdr_q),
    .busy_wait  (busy_wait),
    .beat1      (beat1),
    .done_strb  (done_strb),
    .rd_data    (rd_data)
  );

endmodule

//--- verilog/qdr_read_collect.sv
`timescale 1ns/10ps

module qdr_read_collect #(
  parameter int QDR_LATENCY = 10
) (
  input  logic                                 qdr_clk,
  input  logic                                 qdr_rst,
  input  logic                                 start_strb,
  input  logic                                 rnw,
  input  logic                                 beat_sel,
  input  logic                                 qdr_ack,
  input  logic [qdr_bus_pkg::QDR_DATA_W-1:0]   qdr_q,
  output logic                                 busy_wait,
  output logic                                 beat1,
  output logic                                 done_strb,
  output logic [host_bus_pkg::HOST_DATA_W-1:0] rd_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_COLLECT,
    ST_FINAL
  } state_t;

  state_t state;

  // a read acknowledge walks through here until beat 0 is due
  logic [QDR_LATENCY-1:0] ack_shift;

  logic ack_now;
  logic beat0_due;
  logic take_beat;

  assign busy_wait = (state == ST_WAIT);

  // the request is also up during start_strb, so an early ack counts
  assign ack_now   = (start_strb || busy_wait) && qdr_ack;
  assign beat0_due = (state == ST_COLLECT) && ack_shift[QDR_LATENCY-1];
  assign take_beat = (beat0_due && !beat_sel) || (state == ST_FINAL);

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      state     <= ST_IDLE;
      ack_shift <= '0;
      beat1     <= 1'b0;
      done_strb <= 1'b0;
    end else begin
      ack_shift <= {ack_shift[QDR_LATENCY-2:0], ack_now && rnw};
      beat1     <= ack_now && !rnw;
      done_strb <= 1'b0;

      case (state)
        ST_IDLE, ST_WAIT: begin
          if (ack_now) begin
            // writes are done once the controller accepts them
            done_strb <= !rnw;
            state     <= rnw ? ST_COLLECT : ST_IDLE;
          end else if (start_strb) begin
            state <= ST_WAIT;
          end
        end
        ST_COLLECT: begin
          if (beat0_due) begin
            done_strb <= !beat_sel;
            state     <= beat_sel ? ST_FINAL : ST_IDLE;
          end
        end
        ST_FINAL: begin
          done_strb <= 1'b1;
          state     <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge qdr_clk) begin
    if (take_beat) begin
      rd_data <= qdr_bus_pkg::unpack_lanes(qdr_q);
    end
  end

endmodule

//--- verilog/qdr_cmd_issue.sv
`timescale 1ns/10ps

module qdr_cmd_issue (
  input  logic                   qdr_clk,
  input  logic                   qdr_rst,
  input  logic                   trans_lvl,
  input  host_bus_pkg::host_req_t host_req,
  input  logic                   done_strb,
  output logic                   start_strb,
  output host_bus_pkg::host_req_t cur_req,
  output qdr_bus_pkg::qdr_cmd_t   qdr_cmd,
  output logic                   qdr_req,
  output logic                   resp_lvl,
  input  logic                   busy_wait,
  input  logic                   beat1
);

  typedef enum logic {
    HS_IDLE,
    HS_BUSY
  } hs_state_t;

  hs_state_t hs_state;

  // request level synchronizer
  logic trans_s1;
  logic trans_s2;

  logic take_req;

  // high on the beat that carries the host word
  logic be_beat;

  assign take_req = (hs_state == HS_IDLE) && trans_s2;

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      trans_s1   <= 1'b0;
      trans_s2   <= 1'b0;
      hs_state   <= HS_IDLE;
      start_strb <= 1'b0;
      resp_lvl   <= 1'b0;
    end else begin
      trans_s1   <= trans_lvl;
      trans_s2   <= trans_s1;
      start_strb <= 1'b0;

      case (hs_state)
        HS_IDLE: begin
          if (trans_s2) begin
            start_strb <= 1'b1;
            hs_state   <= HS_BUSY;
          end
        end
        HS_BUSY: begin
          if (done_strb) begin
            resp_lvl <= 1'b1;
          end
          // host has seen the response and dropped its request
          if (!trans_s2) begin
            resp_lvl <= 1'b0;
            hs_state <= HS_IDLE;
          end
        end
        default: hs_state <= HS_IDLE;
      endcase
    end
  end

  // host inputs are stable until host_ack, so no second sync is needed
  always_ff @(posedge qdr_clk) begin
    if (take_req) begin
      cur_req <= host_req;
    end
  end

  assign qdr_req = start_strb | busy_wait;

  // addr bit 2 picks beat 0 or beat 1 of the burst
  assign be_beat = (qdr_req | beat1) && (beat1 == cur_req.addr[2]);

  always_comb begin
    qdr_cmd.r    = qdr_req & cur_req.rnw;
    qdr_cmd.w    = qdr_req & ~cur_req.rnw;
    qdr_cmd.addr = cur_req.addr[host_bus_pkg::HOST_ADDR_W-1:3];
    qdr_cmd.d    = qdr_bus_pkg::pack_lanes(cur_req.wdata);
    qdr_cmd.be   = be_beat ? cur_req.be : '0;
  end

endmodule

//--- verilog/host_req_port.sv
`timescale 1ns/10ps

module host_req_port (
  input  logic                                host_clk,
  input  logic                                host_rst,
  input  logic                                host_en,
  input  logic [host_bus_pkg::HOST_DATA_W-1:0] host_rdata_q,
  input  logic                                resp_lvl,
  output logic                                trans_lvl,
  output logic [host_bus_pkg::HOST_DATA_W-1:0] host_rdata,
  output logic                                host_ack
);

  // two-flop synchronizer for the response level from the QDR domain
  logic resp_s1;
  logic resp_s2;

  // response seen and waiting for it to drop before acking
  logic wait_clear;

  // first cycle of a synchronized response while the request is still up
  logic resp_rise;

  assign resp_rise = resp_s2 && trans_lvl;

  always_ff @(posedge host_clk) begin
    if (host_rst) begin
      resp_s1    <= 1'b0;
      resp_s2    <= 1'b0;
      trans_lvl  <= 1'b0;
      wait_clear <= 1'b0;
      host_ack   <= 1'b0;
    end else begin
      resp_s1  <= resp_lvl;
      resp_s2  <= resp_s1;
      host_ack <= 1'b0;

      if (host_en) begin
        trans_lvl  <= 1'b1;
        wait_clear <= 1'b0;
      end

      // drop the request so the QDR side can release its response
      if (resp_rise) begin
        trans_lvl  <= 1'b0;
        wait_clear <= 1'b1;
      end

      // four-phase handshake closes here
      if (wait_clear && !resp_s2) begin
        wait_clear <= 1'b0;
        host_ack   <= 1'b1;
      end
    end
  end

  // read data is stable in the QDR domain once resp_lvl is high,
  // so it is safe to take it across here
  always_ff @(posedge host_clk) begin
    if (resp_rise) begin
      host_rdata <= host_rdata_q;
    end
  end

endmodule

//--- verilog/qdr_bus_pkg.sv
package qdr_bus_pkg;

  // each byte lane is 9 bits wide and its top bit is the unused parity slot
  localparam int LANE_CNT   = 4;
  localparam int LANE_W     = 9;
  localparam int QDR_ADDR_W = 29;
  localparam int QDR_DATA_W = LANE_CNT * LANE_W;

  // command bus towards the SRAM controller
  typedef struct packed {
    logic                  r;
    logic                  w;
    logic [QDR_ADDR_W-1:0] addr;
    logic [QDR_DATA_W-1:0] d;
    logic [LANE_CNT-1:0]   be;
  } qdr_cmd_t;

  // spread 4 bytes over 4 lanes with the ninth bit of every lane zero
  function automatic logic [QDR_DATA_W-1:0] pack_lanes(input logic [LANE_CNT*8-1:0] data);
    logic [QDR_DATA_W-1:0] lanes;
    lanes = '0;
    for (int i = 0; i < LANE_CNT; i++) begin
      lanes[i*LANE_W +: 8] = data[i*8 +: 8];
    end
    return lanes;
  endfunction

  // drop bits 35, 26, 17 and 8
  function automatic logic [LANE_CNT*8-1:0] unpack_lanes(input logic [QDR_DATA_W-1:0] lanes);
    logic [LANE_CNT*8-1:0] data;
    data = '0;
    for (int i = 0; i < LANE_CNT; i++) begin
      data[i*8 +: 8] = lanes[i*LANE_W +: 8];
    end
    return data;
  endfunction

endpackage

//--- verilog/host_bus_pkg.sv
package host_bus_pkg;

  // host register bus widths
  localparam int HOST_ADDR_W = 32;
  localparam int HOST_DATA_W = 32;
  localparam int HOST_BE_W   = HOST_DATA_W / 8;

  // one host transfer, held stable from host_en until host_ack
  // so the QDR domain can sample it once the request level is synchronized
  typedef struct packed {
    logic                   rnw;
    logic [HOST_ADDR_W-1:0] addr;
    logic [HOST_DATA_W-1:0] wdata;
    logic [HOST_BE_W-1:0]   be;
  } host_req_t;

endpackage
